//--- src/regs_pkg.sv
// Action register map
`default_nettype none

package regs_pkg;

   // Word index, byte address bits 6 to 2
   typedef logic [4:0]   addr_word_t;
   typedef logic [31:0]  reg_word_t;
   typedef logic [127:0] cmd_word_t;
   typedef logic [103:0] cmd_data_t;
   typedef logic [7:0]   req_count_t;

   localparam addr_word_t WORD_CONTROL        = 5'h00;
   localparam addr_word_t WORD_ACTION_TYPE    = 5'h04;
   localparam addr_word_t WORD_ACTION_VERSION = 5'h05;
   localparam addr_word_t WORD_CONTEXT        = 5'h08;
   localparam addr_word_t WORD_TX_STATUS      = 5'h0C;
   localparam addr_word_t WORD_TX_CONTROL     = 5'h0D;
   localparam addr_word_t WORD_TX_CMD0        = 5'h0E;
   localparam addr_word_t WORD_TX_CMD1        = 5'h0F;
   localparam addr_word_t WORD_TX_CMD2        = 5'h10;
   localparam addr_word_t WORD_TX_CMD3        = 5'h11;
   localparam addr_word_t WORD_TX_STS_DATA    = 5'h12;
   localparam addr_word_t WORD_RX_STATUS      = 5'h14;
   localparam addr_word_t WORD_RX_CONTROL     = 5'h15;
   localparam addr_word_t WORD_RX_CMD0        = 5'h16;
   localparam addr_word_t WORD_RX_CMD1        = 5'h17;
   localparam addr_word_t WORD_RX_CMD2        = 5'h18;
   localparam addr_word_t WORD_RX_CMD3        = 5'h19;
   localparam addr_word_t WORD_RX_STS_DATA    = 5'h1A;

   // Channel control bits
   localparam int CTL_PUSH_BIT = 0;
   localparam int CTL_ARM_BIT  = 8;

   // Channel status bits
   localparam int STS_PUSHED    = 0;
   localparam int STS_CMD_VALID = 1;
   localparam int STS_CMD_READY = 2;
   localparam int STS_CMD_FULL  = 3;
   localparam int STS_ARMED     = 8;
   localparam int STS_CAPTURED  = 9;
   localparam int STS_STS_FULL  = 11;
   localparam int STS_COUNT_LSB = 16;

   localparam reg_word_t BAD_READ_DATA = 32'h5A5A_A5A5;

   typedef struct packed {
      reg_word_t control;
      cmd_word_t cmd;
   } chan_regs_t;

endpackage

`default_nettype wire

//--- src/bus_pkg.sv
// AXI-Lite bus types
`default_nettype none

package bus_pkg;

   localparam logic [1:0] RESP_OKAY = 2'b00;

   // Master to slave
   typedef struct packed {
      logic        awvalid;
      logic [31:0] awaddr;
      logic        wvalid;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
      logic        bready;
      logic        arvalid;
      logic [31:0] araddr;
      logic        rready;
   } axil_req_t;

   // Slave to master
   typedef struct packed {
      logic        awready;
      logic        wready;
      logic        bvalid;
      logic [1:0]  bresp;
      logic        arready;
      logic        rvalid;
      logic [31:0] rdata;
      logic [1:0]  rresp;
   } axil_rsp_t;

   // Internal register write, one cycle
   typedef struct packed {
      logic                 valid;
      regs_pkg::addr_word_t word;
      regs_pkg::reg_word_t  data;
      logic [3:0]           strb;
   } wr_cmd_t;

   typedef struct packed {
      logic                 valid;
      regs_pkg::addr_word_t word;
   } rd_cmd_t;

endpackage

`default_nettype wire

//--- src/axil_front.sv
// AXI-Lite slave front end
`timescale 1ns/10ps
`default_nettype none

module axil_front
   import regs_pkg::*, bus_pkg::*;
(
   input  wire logic clk,
   input  wire logic rst_n,
   input  axil_req_t bus_req,
   output axil_rsp_t rsp_ctl,
   output wr_cmd_t   wr_cmd,
   output rd_cmd_t   rd_cmd
);

   typedef enum logic {W_IDLE, W_RESP} wr_state_t;
   typedef enum logic {R_IDLE, R_DATA} rd_state_t;

   wr_state_t wr_state;
   rd_state_t rd_state;
   logic      wr_fire;
   logic      rd_fire;

   // AW and W taken together, only with no response pending
   assign wr_fire = (wr_state == W_IDLE) & bus_req.awvalid & bus_req.wvalid;
   assign rd_fire = (rd_state == R_IDLE) & bus_req.arvalid;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_state <= W_IDLE;
         rd_state <= R_IDLE;
      end else begin
         case (wr_state)
            W_IDLE:  if (wr_fire) wr_state <= W_RESP;
            W_RESP:  if (bus_req.bready) wr_state <= W_IDLE;
            default: wr_state <= W_IDLE;
         endcase
         case (rd_state)
            R_IDLE:  if (rd_fire) rd_state <= R_DATA;
            R_DATA:  if (bus_req.rready) rd_state <= R_IDLE;
            default: rd_state <= R_IDLE;
         endcase
      end
   end

   // Read data joins in the top level
   always_comb begin
      rsp_ctl         = '0;
      rsp_ctl.awready = wr_fire;
      rsp_ctl.wready  = wr_fire;
      rsp_ctl.bvalid  = (wr_state == W_RESP);
      rsp_ctl.bresp   = RESP_OKAY;
      rsp_ctl.arready = (rd_state == R_IDLE);
      rsp_ctl.rvalid  = (rd_state == R_DATA);
      rsp_ctl.rresp   = RESP_OKAY;
   end

   // Byte address to word index
   assign wr_cmd = '{valid: wr_fire,
                     word:  addr_word_t'(bus_req.awaddr[6:2]),
                     data:  bus_req.wdata,
                     strb:  bus_req.wstrb};
   assign rd_cmd = '{valid: rd_fire,
                     word:  addr_word_t'(bus_req.araddr[6:2])};

   a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_ctl.bvalid && !bus_req.bready |=> rsp_ctl.bvalid);

   a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_ctl.rvalid && !bus_req.rready |=> rsp_ctl.rvalid);

endmodule

`default_nettype wire

//--- src/ctrl_regs.sv
// Action and channel control registers
`timescale 1ns/10ps
`default_nettype none

module ctrl_regs
   import regs_pkg::*, bus_pkg::*;
(
   input  wire logic  clk,
   input  wire logic  rst_n,
   input  wr_cmd_t    wr_cmd,
   input  req_count_t tx_count,
   input  req_count_t rx_count,
   output reg_word_t  control,
   output reg_word_t  context_reg,
   output chan_regs_t tx_regs,
   output chan_regs_t rx_regs,
   output logic       start_q,
   output logic       idle_q,
   output logic       action_start
);

   addr_word_t tx_off;
   addr_word_t rx_off;
   logic [6:0] tx_base;
   logic [6:0] rx_base;

   // Byte lanes from new data where strobed
   function automatic reg_word_t merge(reg_word_t old, reg_word_t data, logic [3:0] strb);
      reg_word_t res;
      for (int b = 0; b < 4; b++) begin
         res[8*b +: 8] = strb[b] ? data[8*b +: 8] : old[8*b +: 8];
      end
      return res;
   endfunction

   // Bit offset of the addressed command word
   assign tx_off  = wr_cmd.word - WORD_TX_CMD0;
   assign rx_off  = wr_cmd.word - WORD_RX_CMD0;
   assign tx_base = {tx_off[1:0], 5'd0};
   assign rx_base = {rx_off[1:0], 5'd0};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         control     <= '0;
         context_reg <= '0;
         tx_regs     <= '0;
         rx_regs     <= '0;
      end else if (wr_cmd.valid) begin
         case (wr_cmd.word)
            WORD_CONTROL:
               control <= merge(control, wr_cmd.data, wr_cmd.strb);
            WORD_CONTEXT:
               context_reg <= merge(context_reg, wr_cmd.data, wr_cmd.strb);
            WORD_TX_CONTROL:
               tx_regs.control <= merge(tx_regs.control, wr_cmd.data, wr_cmd.strb);
            WORD_TX_CMD0, WORD_TX_CMD1, WORD_TX_CMD2, WORD_TX_CMD3:
               tx_regs.cmd[tx_base +: 32] <=
                  merge(tx_regs.cmd[tx_base +: 32], wr_cmd.data, wr_cmd.strb);
            WORD_RX_CONTROL:
               rx_regs.control <= merge(rx_regs.control, wr_cmd.data, wr_cmd.strb);
            WORD_RX_CMD0, WORD_RX_CMD1, WORD_RX_CMD2, WORD_RX_CMD3:
               rx_regs.cmd[rx_base +: 32] <=
                  merge(rx_regs.cmd[rx_base +: 32], wr_cmd.data, wr_cmd.strb);
            default: ;
         endcase
      end
   end

   // Start edge detect and idle flag
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         start_q <= 1'b0;
         idle_q  <= 1'b0;
      end else begin
         start_q <= control[0];
         idle_q  <= (tx_count == '0) && (rx_count == '0);
      end
   end

   assign action_start = control[0] & ~start_q;

endmodule

`default_nettype wire

//--- src/queue_chan.sv
// Command push and status capture channel
`timescale 1ns/10ps
`default_nettype none

module queue_chan
   import regs_pkg::*;
#(
   parameter int STS_W = 8
) (
   input  wire logic             clk,
   input  wire logic             rst_n,
   input  chan_regs_t            regs,
   output logic                  cmd_valid,
   input  wire logic             cmd_ready,
   output cmd_data_t             cmd_data,
   input  wire logic             cmd_full,
   input  wire logic             sts_valid,
   output logic                  sts_ready,
   input  wire logic [STS_W-1:0] sts_data,
   input  wire logic             sts_full,
   output reg_word_t             status,
   output reg_word_t             sts_word,
   output req_count_t            count
);

   logic push_rise;
   logic arm_rise;
   logic sts_fire;

   // Rising control bits seen against their status copies
   assign push_rise = regs.control[CTL_PUSH_BIT] & ~status[STS_PUSHED];
   assign arm_rise  = regs.control[CTL_ARM_BIT] & ~status[STS_ARMED];
   assign sts_fire  = sts_valid & sts_ready;

   ////////////////////////////////////////////////////////////////////////////
   // Command and status queue handshakes
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         status    <= '0;
         sts_word  <= '0;
         cmd_valid <= 1'b0;
         sts_ready <= 1'b1;
         count     <= '0;
      end else begin
         if (push_rise) begin
            status[STS_PUSHED] <= 1'b1;
            cmd_valid          <= 1'b1;
         end else if (cmd_valid && cmd_ready) begin
            cmd_valid <= 1'b0;
         end
         // Push bit must drop before the next push
         if (!regs.control[CTL_PUSH_BIT] && status[STS_PUSHED])
            status[STS_PUSHED] <= 1'b0;

         if (sts_fire) begin
            sts_word             <= reg_word_t'(sts_data);
            sts_ready            <= 1'b0;
            status[STS_CAPTURED] <= 1'b1;
         end
         // Re-arm wins over a capture in the same cycle
         if (arm_rise) begin
            status[STS_ARMED]    <= 1'b1;
            status[STS_CAPTURED] <= 1'b0;
            sts_ready            <= 1'b1;
         end
         if (!regs.control[CTL_ARM_BIT] && status[STS_ARMED])
            status[STS_ARMED] <= 1'b0;

         if (push_rise && !sts_fire)
            count <= count + 8'd1;
         else if (!push_rise && sts_fire)
            count <= count - 8'd1;

         status[STS_CMD_VALID]       <= cmd_valid;
         status[STS_CMD_READY]       <= cmd_ready;
         status[STS_CMD_FULL]        <= cmd_full;
         status[STS_STS_FULL]        <= sts_full;
         status[STS_COUNT_LSB +: 8]  <= count;
      end
   end

   // Payload frozen at push time
   always_ff @(posedge clk) begin
      if (push_rise)
         cmd_data <= regs.cmd[103:0];
   end

   a_cmd_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_valid && !cmd_ready |=> cmd_valid);

endmodule

`default_nettype wire

//--- src/read_mux.sv
// Register read-back select
`timescale 1ns/10ps
`default_nettype none

module read_mux
   import regs_pkg::*, bus_pkg::*;
(
   input  wire logic  clk,
   input  wire logic  rst_n,
   input  rd_cmd_t    rd_cmd,
   input  reg_word_t  control,
   input  reg_word_t  context_reg,
   input  reg_word_t  action_type,
   input  reg_word_t  action_version,
   input  wire logic  start_q,
   input  wire logic  idle_q,
   input  chan_regs_t tx_regs,
   input  chan_regs_t rx_regs,
   input  reg_word_t  tx_status,
   input  reg_word_t  tx_sts_word,
   input  reg_word_t  rx_status,
   input  reg_word_t  rx_sts_word,
   output reg_word_t  rdata
);

   reg_word_t  ctrl_rd;
   reg_word_t  sel;
   addr_word_t tx_off;
   addr_word_t rx_off;
   logic [6:0] tx_base;
   logic [6:0] rx_base;

   // Bit 3 ready, bit 2 idle, bit 0 start
   assign ctrl_rd = {control[31:4], 1'b1, idle_q, 1'b0, start_q};

   assign tx_off  = rd_cmd.word - WORD_TX_CMD0;
   assign rx_off  = rd_cmd.word - WORD_RX_CMD0;
   assign tx_base = {tx_off[1:0], 5'd0};
   assign rx_base = {rx_off[1:0], 5'd0};

   always_comb begin
      case (rd_cmd.word)
         WORD_CONTROL:        sel = ctrl_rd;
         WORD_ACTION_TYPE:    sel = action_type;
         WORD_ACTION_VERSION: sel = action_version;
         WORD_CONTEXT:        sel = context_reg;
         WORD_TX_STATUS:      sel = tx_status;
         WORD_TX_CONTROL:     sel = tx_regs.control;
         WORD_TX_CMD0, WORD_TX_CMD1, WORD_TX_CMD2, WORD_TX_CMD3:
            sel = tx_regs.cmd[tx_base +: 32];
         WORD_TX_STS_DATA:    sel = tx_sts_word;
         WORD_RX_STATUS:      sel = rx_status;
         WORD_RX_CONTROL:     sel = rx_regs.control;
         WORD_RX_CMD0, WORD_RX_CMD1, WORD_RX_CMD2, WORD_RX_CMD3:
            sel = rx_regs.cmd[rx_base +: 32];
         WORD_RX_STS_DATA:    sel = rx_sts_word;
         default:             sel = BAD_READ_DATA;
      endcase
   end

   // Held until the next accepted read
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         rdata <= '0;
      else if (rd_cmd.valid)
         rdata <= sel;
   end

endmodule

`default_nettype wire

//--- src/action_regs_top.sv
// Action register block top
`timescale 1ns/10ps
`default_nettype none

module action_regs_top
   import regs_pkg::*, bus_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst_n,
   input  axil_req_t        bus_req,
   output axil_rsp_t        bus_rsp,
   input  reg_word_t        action_type,
   input  reg_word_t        action_version,
   output reg_word_t        context_out,
   output logic             action_start,
   output logic             tx_cmd_valid,
   input  wire logic        tx_cmd_ready,
   output cmd_data_t        tx_cmd_data,
   input  wire logic        tx_cmd_full,
   input  wire logic        tx_sts_valid,
   output logic             tx_sts_ready,
   input  wire logic [7:0]  tx_sts_data,
   input  wire logic        tx_sts_full,
   output logic             rx_cmd_valid,
   input  wire logic        rx_cmd_ready,
   output cmd_data_t        rx_cmd_data,
   input  wire logic        rx_cmd_full,
   input  wire logic        rx_sts_valid,
   output logic             rx_sts_ready,
   input  wire logic [31:0] rx_sts_data,
   input  wire logic        rx_sts_full
);

   axil_rsp_t  rsp_ctl;
   wr_cmd_t    wr_cmd;
   rd_cmd_t    rd_cmd;
   reg_word_t  control;
   reg_word_t  rdata;
   reg_word_t  tx_status;
   reg_word_t  tx_sts_word;
   reg_word_t  rx_status;
   reg_word_t  rx_sts_word;
   chan_regs_t tx_regs;
   chan_regs_t rx_regs;
   req_count_t tx_count;
   req_count_t rx_count;
   logic       start_q;
   logic       idle_q;

   // Handshakes from the front end, data from the mux
   always_comb begin
      bus_rsp       = rsp_ctl;
      bus_rsp.rdata = rdata;
   end

   axil_front u_front (
      .clk, .rst_n, .bus_req, .rsp_ctl, .wr_cmd, .rd_cmd
   );

   ctrl_regs u_ctrl (
      .clk, .rst_n, .wr_cmd, .tx_count, .rx_count, .control,
      .context_reg(context_out), .tx_regs, .rx_regs, .start_q, .idle_q, .action_start
   );

   queue_chan #(.STS_W(8)) u_tx_chan (
      .clk, .rst_n, .regs(tx_regs),
      .cmd_valid(tx_cmd_valid), .cmd_ready(tx_cmd_ready), .cmd_data(tx_cmd_data),
      .cmd_full(tx_cmd_full), .sts_valid(tx_sts_valid), .sts_ready(tx_sts_ready),
      .sts_data(tx_sts_data), .sts_full(tx_sts_full),
      .status(tx_status), .sts_word(tx_sts_word), .count(tx_count)
   );

   queue_chan #(.STS_W(32)) u_rx_chan (
      .clk, .rst_n, .regs(rx_regs),
      .cmd_valid(rx_cmd_valid), .cmd_ready(rx_cmd_ready), .cmd_data(rx_cmd_data),
      .cmd_full(rx_cmd_full), .sts_valid(rx_sts_valid), .sts_ready(rx_sts_ready),
      .sts_data(rx_sts_data), .sts_full(rx_sts_full),
      .status(rx_status), .sts_word(rx_sts_word), .count(rx_count)
   );

   read_mux u_read_mux (
      .clk, .rst_n, .rd_cmd, .control, .context_reg(context_out),
      .action_type, .action_version, .start_q, .idle_q, .tx_regs, .rx_regs,
      .tx_status, .tx_sts_word, .rx_status, .rx_sts_word, .rdata
   );

endmodule

`default_nettype wire

//--- dv/tb_action_regs.sv
// Action register block testbench
`timescale 1ns/10ps
`default_nettype none

module tb_action_regs
   import regs_pkg::*, bus_pkg::*;
;

   localparam int MAX_CYCLES = 2000;

   logic       clk;
   logic       rst_n;
   axil_req_t  bus_req;
   axil_rsp_t  bus_rsp;
   reg_word_t  action_type;
   reg_word_t  action_version;
   reg_word_t  context_out;
   logic       action_start;
   logic       tx_cmd_valid;
   logic       tx_cmd_ready;
   cmd_data_t  tx_cmd_data;
   logic       tx_cmd_full;
   logic       tx_sts_valid;
   logic       tx_sts_ready;
   logic [7:0] tx_sts_data;
   logic       tx_sts_full;
   logic       rx_cmd_valid;
   logic       rx_cmd_ready;
   cmd_data_t  rx_cmd_data;
   logic       rx_cmd_full;
   logic       rx_sts_valid;
   logic       rx_sts_ready;
   logic [31:0] rx_sts_data;
   logic       rx_sts_full;

   integer     seed = 50404;
   int         cycles = 0;
   int         error_count = 0;
   int         check_count = 0;
   int         start_pulses = 0;

   // Shadow register model
   reg_word_t  control_sh;
   reg_word_t  context_sh;
   reg_word_t  tx_ctl_sh;
   reg_word_t  rx_ctl_sh;
   reg_word_t  tx_cmd_sh [4];
   reg_word_t  rx_cmd_sh [4];
   reg_word_t  tx_stat_sh;
   reg_word_t  rx_stat_sh;
   reg_word_t  tx_sword_sh;
   reg_word_t  rx_sword_sh;
   logic       idle_sh;

   action_regs_top u_action_regs_top (
      .clk, .rst_n, .bus_req, .bus_rsp, .action_type, .action_version,
      .context_out, .action_start,
      .tx_cmd_valid, .tx_cmd_ready, .tx_cmd_data, .tx_cmd_full,
      .tx_sts_valid, .tx_sts_ready, .tx_sts_data, .tx_sts_full,
      .rx_cmd_valid, .rx_cmd_ready, .rx_cmd_data, .rx_cmd_full,
      .rx_sts_valid, .rx_sts_ready, .rx_sts_data, .rx_sts_full
   );

   always #5 clk = ~clk;

   // Cycle limit
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, a handshake never completed", cycles);
         $display("Test failures found");
         $finish;
      end
   end

   always @(negedge clk) begin
      if (action_start)
         start_pulses <= start_pulses + 1;
   end

   function automatic reg_word_t merge_bytes(reg_word_t old, reg_word_t data,
                                             logic [3:0] strb);
      reg_word_t res;
      for (int b = 0; b < 4; b++) begin
         res[8*b +: 8] = strb[b] ? data[8*b +: 8] : old[8*b +: 8];
      end
      return res;
   endfunction

   // Expected read-back for one word index
   function automatic reg_word_t expected_read(addr_word_t word);
      reg_word_t exp;
      case (word)
         WORD_CONTROL:        exp = {control_sh[31:4], 1'b1, idle_sh, 1'b0, control_sh[0]};
         WORD_ACTION_TYPE:    exp = action_type;
         WORD_ACTION_VERSION: exp = action_version;
         WORD_CONTEXT:        exp = context_sh;
         WORD_TX_STATUS:      exp = tx_stat_sh;
         WORD_TX_CONTROL:     exp = tx_ctl_sh;
         WORD_TX_CMD0:        exp = tx_cmd_sh[0];
         WORD_TX_CMD1:        exp = tx_cmd_sh[1];
         WORD_TX_CMD2:        exp = tx_cmd_sh[2];
         WORD_TX_CMD3:        exp = tx_cmd_sh[3];
         WORD_TX_STS_DATA:    exp = tx_sword_sh;
         WORD_RX_STATUS:      exp = rx_stat_sh;
         WORD_RX_CONTROL:     exp = rx_ctl_sh;
         WORD_RX_CMD0:        exp = rx_cmd_sh[0];
         WORD_RX_CMD1:        exp = rx_cmd_sh[1];
         WORD_RX_CMD2:        exp = rx_cmd_sh[2];
         WORD_RX_CMD3:        exp = rx_cmd_sh[3];
         WORD_RX_STS_DATA:    exp = rx_sword_sh;
         default:             exp = 32'h5A5A_A5A5;
      endcase
      return exp;
   endfunction

   task automatic check_word(string name, logic [127:0] got, logic [127:0] exp);
      check_count++;
      if (got !== exp) begin
         $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
         error_count++;
      end
   endtask

   task automatic bus_write(addr_word_t word, reg_word_t data, logic [3:0] strb);
      @(negedge clk);
      bus_req.awvalid = 1'b1;
      bus_req.awaddr  = {25'd0, word, 2'b00};
      bus_req.wvalid  = 1'b1;
      bus_req.wdata   = data;
      bus_req.wstrb   = strb;
      #1;
      while (!bus_rsp.awready) begin
         @(negedge clk);
         #1;
      end
      check_word("wready", bus_rsp.wready, 1'b1);
      @(negedge clk);
      bus_req.awvalid = 1'b0;
      bus_req.wvalid  = 1'b0;
      while (!bus_rsp.bvalid)
         @(negedge clk);
      check_word("bresp", bus_rsp.bresp, 2'b00);
   endtask

   task automatic bus_read(addr_word_t word, output reg_word_t data);
      @(negedge clk);
      bus_req.arvalid = 1'b1;
      bus_req.araddr  = {25'd0, word, 2'b00};
      #1;
      while (!bus_rsp.arready) begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      bus_req.arvalid = 1'b0;
      while (!bus_rsp.rvalid)
         @(negedge clk);
      check_word("rresp", bus_rsp.rresp, 2'b00);
      data = bus_rsp.rdata;
   endtask

   // Read one word and compare it with the shadow model
   task automatic check_read(addr_word_t word);
      reg_word_t got;
      bus_read(word, got);
      check_count++;
      if (got !== expected_read(word)) begin
         $display("[FAIL] rdata word 0x%0h got 0x%0h expected 0x%0h",
                  word, got, expected_read(word));
         error_count++;
      end
   endtask

   task automatic wait_cycles(int n);
      repeat (n) @(negedge clk);
   endtask

   initial begin
      reg_word_t rnd;
      reg_word_t rnd2;
      reg_word_t rd;
      int        sel;
      clk = 1'b0;
      rst_n = 1'b0;
      bus_req = '0;
      bus_req.bready = 1'b1;
      bus_req.rready = 1'b1;
      action_type = 32'h1014_0000;
      action_version = 32'h0000_0203;
      tx_cmd_ready = 1'b0;
      tx_cmd_full = 1'b0;
      tx_sts_valid = 1'b0;
      tx_sts_data = '0;
      tx_sts_full = 1'b0;
      rx_cmd_ready = 1'b0;
      rx_cmd_full = 1'b0;
      rx_sts_valid = 1'b0;
      rx_sts_data = '0;
      rx_sts_full = 1'b0;
      control_sh = '0;
      context_sh = '0;
      tx_ctl_sh = '0;
      rx_ctl_sh = '0;
      tx_stat_sh = '0;
      rx_stat_sh = '0;
      tx_sword_sh = '0;
      rx_sword_sh = '0;
      idle_sh = 1'b1;
      for (int i = 0; i < 4; i++) begin
         tx_cmd_sh[i] = '0;
         rx_cmd_sh[i] = '0;
      end
      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      ///////////////////////////////////////////////////////////////////////////
      // Reset values
      ///////////////////////////////////////////////////////////////////////////
      check_word("bvalid", bus_rsp.bvalid, 1'b0);
      check_word("rvalid", bus_rsp.rvalid, 1'b0);
      check_word("tx_sts_ready", tx_sts_ready, 1'b1);
      check_word("rx_sts_ready", rx_sts_ready, 1'b1);
      wait_cycles(2);
      bus_read(WORD_CONTROL, rd);
      check_word("control rdata", rd, 32'h0000_000C);
      check_read(WORD_CONTEXT);
      for (int i = 0; i < 4; i++) begin
         check_read(addr_word_t'(WORD_TX_CMD0 + i));
         check_read(addr_word_t'(WORD_RX_CMD0 + i));
      end

      // Random strobed writes
      for (int i = 0; i < 24; i++) begin
         rnd  = $random(seed);
         rnd2 = $random(seed);
         sel  = int'(rnd2[7:4]) % 9;
         if (sel == 0) begin
            bus_write(WORD_CONTEXT, rnd, rnd2[3:0]);
            context_sh = merge_bytes(context_sh, rnd, rnd2[3:0]);
         end else if (sel < 5) begin
            bus_write(addr_word_t'(WORD_TX_CMD0 + sel - 1), rnd, rnd2[3:0]);
            tx_cmd_sh[sel-1] = merge_bytes(tx_cmd_sh[sel-1], rnd, rnd2[3:0]);
         end else begin
            bus_write(addr_word_t'(WORD_RX_CMD0 + sel - 5), rnd, rnd2[3:0]);
            rx_cmd_sh[sel-5] = merge_bytes(rx_cmd_sh[sel-5], rnd, rnd2[3:0]);
         end
      end
      check_read(WORD_CONTEXT);
      check_word("context_out", context_out, context_sh);
      for (int i = 0; i < 4; i++) begin
         check_read(addr_word_t'(WORD_TX_CMD0 + i));
         check_read(addr_word_t'(WORD_RX_CMD0 + i));
      end
      check_read(WORD_ACTION_TYPE);
      check_read(WORD_ACTION_VERSION);
      check_read(5'h1F);
      check_read(5'h01);

      // Start pulse
      start_pulses = 0;
      bus_write(WORD_CONTROL, 32'h0000_0001, 4'hF);
      control_sh = 32'h0000_0001;
      wait_cycles(4);
      check_word("action_start pulses", start_pulses, 1);
      check_read(WORD_CONTROL);

      ///////////////////////////////////////////////////////////////////////////
      // Tx push against a stalled command queue
      ///////////////////////////////////////////////////////////////////////////
      bus_write(WORD_TX_CONTROL, 32'h0000_0001, 4'hF);
      tx_ctl_sh = 32'h0000_0001;
      while (!tx_cmd_valid)
         @(negedge clk);
      wait_cycles(3);
      check_word("tx_cmd_valid", tx_cmd_valid, 1'b1);
      check_word("tx_cmd_data", tx_cmd_data,
                 104'({tx_cmd_sh[3], tx_cmd_sh[2], tx_cmd_sh[1], tx_cmd_sh[0]}));
      tx_cmd_ready = 1'b1;
      while (tx_cmd_valid)
         @(negedge clk);
      tx_stat_sh = 32'h0001_0005;
      idle_sh = 1'b0;
      check_read(WORD_TX_STATUS);
      check_read(WORD_CONTROL);

      // Tx status capture and re-arm
      rnd = $random(seed);
      tx_sts_data = rnd[7:0];
      tx_sts_valid = 1'b1;
      while (tx_sts_ready)
         @(negedge clk);
      tx_sts_valid = 1'b0;
      tx_sword_sh = {24'd0, rnd[7:0]};
      tx_stat_sh = 32'h0000_0205;
      idle_sh = 1'b1;
      check_read(WORD_TX_STS_DATA);
      check_read(WORD_TX_STATUS);
      check_read(WORD_CONTROL);
      bus_write(WORD_TX_CONTROL, 32'h0000_0101, 4'hF);
      tx_ctl_sh = 32'h0000_0101;
      while (!tx_sts_ready)
         @(negedge clk);
      tx_stat_sh = 32'h0000_0105;
      check_read(WORD_TX_STATUS);

      ///////////////////////////////////////////////////////////////////////////
      // Rx channel, tx must stay put
      ///////////////////////////////////////////////////////////////////////////
      bus_write(WORD_RX_CONTROL, 32'h0000_0001, 4'hF);
      rx_ctl_sh = 32'h0000_0001;
      while (!rx_cmd_valid)
         @(negedge clk);
      check_word("rx_cmd_data", rx_cmd_data,
                 104'({rx_cmd_sh[3], rx_cmd_sh[2], rx_cmd_sh[1], rx_cmd_sh[0]}));
      rx_cmd_ready = 1'b1;
      while (rx_cmd_valid)
         @(negedge clk);
      rx_stat_sh = 32'h0001_0005;
      idle_sh = 1'b0;
      check_read(WORD_RX_STATUS);
      check_read(WORD_CONTROL);
      rnd = $random(seed);
      rx_sts_data = rnd;
      rx_sts_valid = 1'b1;
      while (rx_sts_ready)
         @(negedge clk);
      rx_sts_valid = 1'b0;
      rx_sword_sh = rnd;
      rx_stat_sh = 32'h0000_0205;
      idle_sh = 1'b1;
      check_read(WORD_RX_STS_DATA);
      check_read(WORD_RX_STATUS);
      bus_write(WORD_RX_CONTROL, 32'h0000_0101, 4'hF);
      rx_ctl_sh = 32'h0000_0101;
      while (!rx_sts_ready)
         @(negedge clk);
      rx_stat_sh = 32'h0000_0105;
      check_read(WORD_RX_STATUS);
      check_read(WORD_TX_STATUS);
      check_read(WORD_TX_STS_DATA);
      check_read(WORD_CONTROL);

      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

//--- vlog.f
src/regs_pkg.sv
src/bus_pkg.sv
src/axil_front.sv
src/ctrl_regs.sv
src/queue_chan.sv
src/read_mux.sv
src/action_regs_top.sv
dv/tb_action_regs.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the action register testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f \
   --top-module tb_action_regs -o tb_action_regs

./obj_dir/tb_action_regs > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
   exit 0
fi
exit 1
